// ==== src.f ====
verilog/mmioPkg.sv
verilog/uartPkg.sv
verilog/microTimer.sv
verilog/uartTransmitter.sv
verilog/uartReceiver.sv
verilog/mmioGpioUart.sv
testbench/mmioGpioUartTb.sv

// ==== testbench/mmioGpioUartTb.sv ====
// testbench for the MMIO peripheral block: GPIO, timers, UART transmit and receive, decode
`timescale 1ns/1ps

module mmioGpioUartTb;

	// one UART bit in clock cycles, from the two fractional increments
	localparam int bitCycles = int'((64'd65536 * 64'd65536) /
		(64'(uartPkg::baudIncrement) * 64'(uartPkg::tickIncrement)));
	// serial bytes sent or captured over the whole run
	localparam int serialBytes = 3 + 8 + 4 + 9;
	localparam int byteTime = 10 * bitCycles;
	localparam int cycleLimit = serialBytes * 14 * byteTime + 2000;
	localparam int busWait = 20;

	logic                 clock;
	logic                 reset;
	mmioPkg::mmioRequest  request;
	mmioPkg::mmioResponse response;
	logic [31:0]          gpioIn;
	logic [31:0]          gpioOut;
	logic [31:0]          gpioDir;
	logic                 uartRx;
	logic                 uartTx;
	logic [63:0]          microseconds;
	logic [63:0]          cycles;

	int          cycleCount;
	int          resetCycles;
	int          valueErrors;
	int          otherErrors;
	integer      seed;
	logic [31:0] expOut;
	logic [31:0] expDir;

	mmioGpioUart dut_i
	(
		.clock(clock),
		.reset(reset),
		.request(request),
		.response(response),
		.gpioIn(gpioIn),
		.gpioOut(gpioOut),
		.gpioDir(gpioDir),
		.uartRx(uartRx),
		.uartTx(uartTx),
		.microseconds(microseconds),
		.cycles(cycles)
	);

	initial
		clock = 1'b0;

	always #4 clock = ~clock;

	always @(posedge clock)
		cycleCount <= cycleCount + 1;

	initial
	begin
		while (cycleCount < cycleLimit)
			@(posedge clock);
		$display("run hung: no end after %0d cycles", cycleLimit);
		$display("TEST FAILED");
		$finish;
	end

	// expected gpioOut after a write of the given kind
	function automatic logic [31:0] gpioModel(input logic [31:0] current,
		input logic [15:0] offset, input logic [31:0] data);
		case (offset)
			mmioPkg::regGpioOut:
				return data;
			mmioPkg::regGpioSet:
				return current | data;
			mmioPkg::regGpioClear:
				return current & ~data;
			default:
				return current;
		endcase
	endfunction

	function automatic uartPkg::uartStatus statusOf(input logic txFull, input logic txEmpty,
		input logic rxFull, input logic rxReady);
		uartPkg::uartStatus s;
		s.txFull = txFull;
		s.txEmpty = txEmpty;
		s.rxFull = rxFull;
		s.rxReady = rxReady;
		return s;
	endfunction

	task automatic checkWord(input logic [63:0] actual, input logic [63:0] expected,
		input logic [63:0] slack, input string what);
		logic [63:0] distance;
		distance = (actual >= expected) ? actual - expected : expected - actual;
		if (distance > slack)
		begin
			valueErrors++;
			$display("[FAIL] %0t: %s expected %h got %h", $time, what, expected, actual);
		end
	endtask

	task automatic checkStatus(input uartPkg::uartStatus actual,
		input uartPkg::uartStatus expected, input string what);
		if (actual !== expected)
		begin
			valueErrors++;
			$display("[FAIL] %0t: %s expected %b got %b", $time, what, expected, actual);
		end
	endtask

	task automatic checkByte(input logic [7:0] actual, input logic [7:0] expected,
		input string what);
		if (actual !== expected)
		begin
			valueErrors++;
			$display("[FAIL] %0t: %s expected %h got %h", $time, what, expected, actual);
		end
	endtask

	// called and left on a falling edge
	task automatic busAccess(input mmioPkg::mmioOpm opm, input logic [11:0] select,
		input logic [15:0] offset, input logic [63:0] data, input int maxWait,
		output logic [63:0] rdata, output logic answered, output int startCycle);
		int waited;
		request.opm = opm;
		request.addr = {4'h0, select, offset};
		request.data = data;
		startCycle = cycleCount;
		answered = 1'b0;
		rdata = 64'd0;
		waited = 0;
		while (!answered && waited < maxWait)
		begin
			@(negedge clock);
			waited++;
			if (response.ok == mmioPkg::ok)
			begin
				answered = 1'b1;
				rdata = response.data;
			end
		end
		// one idle cycle between accesses
		request.opm = mmioPkg::idle;
		@(negedge clock);
	endtask

	task automatic busRead(input mmioPkg::mmioOpm opm, input logic [15:0] offset,
		output logic [63:0] rdata, output int startCycle);
		logic answered;
		busAccess(opm, mmioPkg::blockSelect, offset, 64'd0, busWait, rdata, answered,
			startCycle);
		if (!answered)
		begin
			otherErrors++;
			$display("read of offset %h got no answer at %0t", offset, $time);
		end
	endtask

	task automatic busWrite(input logic [15:0] offset, input logic [63:0] data);
		logic [63:0] unused;
		logic        answered;
		int          startCycle;
		busAccess(mmioPkg::writeWord, mmioPkg::blockSelect, offset, data, busWait, unused,
			answered, startCycle);
		if (!answered)
		begin
			otherErrors++;
			$display("write to offset %h got no answer at %0t", offset, $time);
		end
	endtask

	task automatic readStatus(input uartPkg::uartStatus expected, input string what);
		logic [63:0] rdata;
		int          startCycle;
		busRead(mmioPkg::readWord, mmioPkg::regStatus, rdata, startCycle);
		checkStatus(uartPkg::uartStatus'(rdata[3:0]), expected, what);
	endtask

	// 8N1 frame, LSB first
	task automatic serialSend(input logic [7:0] value);
		logic [9:0] frame;
		int         i;
		frame = {1'b1, value, 1'b0};
		for (i = 0; i < 10; i++)
		begin
			uartRx = frame[i];
			repeat (bitCycles) @(negedge clock);
		end
	endtask

	task automatic serialCapture(output logic [7:0] value);
		logic [9:0] frame;
		int         i;
		while (uartTx !== 1'b0)
			@(negedge clock);
		repeat (bitCycles / 2) @(negedge clock);
		for (i = 0; i < 10; i++)
		begin
			frame[i] = uartTx;
			if (i < 9)
				repeat (bitCycles) @(negedge clock);
		end
		if (frame[0] !== 1'b0)
		begin
			otherErrors++;
			$display("framing error on uartTx at %0t: start bit not low", $time);
		end
		if (frame[9] !== 1'b1)
		begin
			otherErrors++;
			$display("framing error on uartTx at %0t: stop bit not high", $time);
		end
		value = frame[8:1];
	endtask

	task automatic resetTest();
		logic [63:0] rdata;
		int          startCycle;
		checkWord(64'(response.ok), 64'(mmioPkg::ready), 0, "response status after reset");
		checkWord(64'(uartTx), 64'd1, 0, "uartTx after reset");
		busRead(mmioPkg::readWord, mmioPkg::regGpioOut, rdata, startCycle);
		checkWord(rdata, 64'd0, 0, "gpioOut after reset");
		busRead(mmioPkg::readWord, mmioPkg::regGpioDir, rdata, startCycle);
		checkWord(rdata, 64'd0, 0, "gpioDir after reset");
	endtask

	task automatic gpioTest();
		logic [15:0] kinds [4];
		logic [15:0] offset;
		logic [31:0] value;
		logic [63:0] rdata;
		int          startCycle;
		int          i;
		kinds[0] = mmioPkg::regGpioOut;
		kinds[1] = mmioPkg::regGpioDir;
		kinds[2] = mmioPkg::regGpioSet;
		kinds[3] = mmioPkg::regGpioClear;
		for (i = 0; i < 16; i++)
		begin
			offset = kinds[$unsigned($random(seed)) % 4];
			value = $random(seed);
			busWrite(offset, {32'd0, value});
			expOut = gpioModel(expOut, offset, value);
			if (offset == mmioPkg::regGpioDir)
				expDir = value;
			busRead(mmioPkg::readWord, mmioPkg::regGpioOut, rdata, startCycle);
			checkWord(rdata, {32'd0, expOut}, 0, "gpioOut register");
			busRead(mmioPkg::readWord, mmioPkg::regGpioDir, rdata, startCycle);
			checkWord(rdata, {32'd0, expDir}, 0, "gpioDir register");
			checkWord({32'd0, gpioOut}, {32'd0, expOut}, 0, "gpioOut pins");
			checkWord({32'd0, gpioDir}, {32'd0, expDir}, 0, "gpioDir pins");
		end
		gpioIn = $random(seed);
		busRead(mmioPkg::readWord, mmioPkg::regGpioIn, rdata, startCycle);
		checkWord(rdata, {32'd0, gpioIn}, 0, "gpioIn register");
	endtask

	task automatic timerTest();
		logic [63:0] first;
		logic [63:0] second;
		int          startA;
		int          startB;
		int          span;
		int          sinceReset;
		busRead(mmioPkg::readQuad, mmioPkg::regTimerLow, first, startA);
		repeat (500) @(negedge clock);
		busRead(mmioPkg::readQuad, mmioPkg::regTimerLow, second, startB);
		span = startB - startA;
		// whole microseconds in the span, floor of span * increment / 2^16
		checkWord(second - first, (64'(span) * 64'(uartPkg::tickIncrement)) >> 16, 1,
			"microsecond advance");
		busRead(mmioPkg::readQuad, mmioPkg::regCycles, first, startA);
		repeat (123) @(negedge clock);
		busRead(mmioPkg::readQuad, mmioPkg::regCycles, second, startB);
		span = startB - startA;
		checkWord(second - first, 64'(span), 0, "cycle counter advance");
		busRead(mmioPkg::readWord, mmioPkg::regTimerHigh, second, startA);
		busRead(mmioPkg::readQuad, mmioPkg::regTimerLow, first, startB);
		checkWord(second, {32'd0, first[63:32]}, 0, "timer high word");
		// pins count every clock since reset was released
		sinceReset = cycleCount - resetCycles;
		checkWord(cycles, 64'(sinceReset), 0, "cycles pins");
		checkWord(microseconds, (64'(sinceReset) * 64'(uartPkg::tickIncrement)) >> 16, 0,
			"microseconds pins");
	endtask

	task automatic transmitTest(input int written, input int expected);
		logic [7:0] sent [$];
		logic [7:0] value;
		logic [7:0] seen;
		int         i;
		int         quiet;
		logic       extra;
		for (i = 0; i < written; i++)
		begin
			value = 8'($random(seed));
			sent.push_back(value);
			busWrite(mmioPkg::regTxData, {56'd0, value});
		end
		if (written > expected)
			readStatus(statusOf(1'b1, 1'b0, 1'b0, 1'b0), "status with transmit FIFO full");
		for (i = 0; i < expected; i++)
		begin
			serialCapture(seen);
			checkByte(seen, sent[i], "byte on uartTx");
		end
		// a dropped byte must never show up on the line
		if (written > expected)
		begin
			extra = 1'b0;
			for (quiet = 0; quiet < 20 * bitCycles; quiet++)
			begin
				if (uartTx === 1'b0)
					extra = 1'b1;
				@(negedge clock);
			end
			if (extra)
			begin
				otherErrors++;
				$display("uartTx sent a frame for a byte written to a full FIFO");
			end
		end
		else
			repeat (bitCycles) @(negedge clock);
		readStatus(statusOf(1'b0, 1'b1, 1'b0, 1'b0), "status after transmit");
	endtask

	task automatic receiveTest(input int count);
		logic [7:0]  sent [$];
		logic [7:0]  value;
		logic [63:0] rdata;
		int          startCycle;
		int          kept;
		int          i;
		for (i = 0; i < count; i++)
		begin
			value = 8'($random(seed));
			sent.push_back(value);
			serialSend(value);
		end
		repeat (bitCycles / 2) @(negedge clock);
		kept = (count > uartPkg::fifoDepth) ? uartPkg::fifoDepth : count;
		readStatus(statusOf(1'b0, 1'b1, kept == uartPkg::fifoDepth, 1'b1),
			"status after receive");
		for (i = 0; i < kept; i++)
		begin
			busRead(mmioPkg::readWord, mmioPkg::regRxData, rdata, startCycle);
			checkWord(rdata >> 8, 64'd0, 0, "receive data upper bits");
			checkByte(rdata[7:0], sent[i], "byte from regRxData");
		end
		readStatus(statusOf(1'b0, 1'b1, 1'b0, 1'b0), "status after draining receive FIFO");
	endtask

	task automatic decodeTest();
		logic [63:0] rdata;
		logic        answered;
		int          startCycle;
		busAccess(mmioPkg::readWord, 12'h001, mmioPkg::regStatus, 64'd0, 50, rdata, answered,
			startCycle);
		if (answered)
		begin
			otherErrors++;
			$display("request outside the block select was answered at %0t", $time);
		end
		repeat (2) @(negedge clock);
		checkWord(64'(response.ok), 64'(mmioPkg::ready), 0, "response status after idle");
	endtask

	initial
	begin
		seed = 58019;
		cycleCount = 0;
		resetCycles = 0;
		valueErrors = 0;
		otherErrors = 0;
		expOut = 32'd0;
		expDir = 32'd0;
		reset = 1'b1;
		request.opm = mmioPkg::idle;
		request.addr = 32'd0;
		request.data = 64'd0;
		gpioIn = 32'd0;
		uartRx = 1'b1;
		repeat (2) @(negedge clock);
		reset = 1'b0;
		resetCycles = cycleCount;
		@(negedge clock);

		resetTest();
		gpioTest();
		timerTest();
		transmitTest(3, 3);
		receiveTest(4);
		// nine bytes against eight entries
		transmitTest(9, 8);
		receiveTest(9);
		decodeTest();

		$display("checks done: %0d wrong values, %0d other failures", valueErrors,
			otherErrors);
		if (valueErrors == 0 && otherErrors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== verilog/microTimer.sv ====
// microsecond timer driven by a fractional accumulator, with a free-running cycle counter
`timescale 1ns/1ps

module microTimer
(
	input  logic        clock,
	input  logic        reset,
	output logic        tick,
	output logic [63:0] microseconds,
	output logic [63:0] cycles
);

	logic [15:0] fraction;
	logic [15:0] nextFraction;
	logic        carry;

	// carry out of the fraction marks one microsecond
	assign {carry, nextFraction} = {1'b0, fraction} + {1'b0, uartPkg::tickIncrement};

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			fraction <= 16'd0;
			tick <= 1'b0;
			microseconds <= 64'd0;
			cycles <= 64'd0;
		end
		else
		begin
			fraction <= nextFraction;
			tick <= carry;
			cycles <= cycles + 64'd1;
			if (carry)
				microseconds <= microseconds + 64'd1;
		end
	end

endmodule

// ==== verilog/mmioGpioUart.sv ====
// MMIO peripheral block with microsecond timer, cycle counter, UART and 32 GPIO pins
`timescale 1ns/1ps

module mmioGpioUart
(
	input  logic                 clock,
	input  logic                 reset,
	input  mmioPkg::mmioRequest  request,
	output mmioPkg::mmioResponse response,
	input  logic [31:0]          gpioIn,
	output logic [31:0]          gpioOut,
	output logic [31:0]          gpioDir,
	input  logic                 uartRx,
	output logic                 uartTx,
	output logic [63:0]          microseconds,
	output logic [63:0]          cycles
);

	mmioPkg::mmioRequest captured;
	mmioPkg::mmioOpm     lastOpm;
	mmioPkg::mmioOk      nextOk;
	logic [63:0]         nextData;
	logic [15:0]         offset;
	logic                blockHit;
	logic                isRead;
	logic                isWrite;
	logic                isQuad;
	logic                firstCycle;
	logic                known;
	logic                tick;
	logic                pushValid;
	logic                popValid;
	logic [7:0]          headByte;
	logic [7:0]          heldByte;
	logic [7:0]          rxByte;
	uartPkg::uartStatus  status;

	microTimer timer
	(
		.clock(clock),
		.reset(reset),
		.tick(tick),
		.microseconds(microseconds),
		.cycles(cycles)
	);

	uartTransmitter transmitter
	(
		.clock(clock),
		.reset(reset),
		.tick(tick),
		.pushValid(pushValid),
		.pushByte(captured.data[7:0]),
		.uartTx(uartTx),
		.txFull(status.txFull),
		.txEmpty(status.txEmpty)
	);

	uartReceiver receiver
	(
		.clock(clock),
		.reset(reset),
		.tick(tick),
		.popValid(popValid),
		.uartRx(uartRx),
		.headByte(headByte),
		.rxFull(status.rxFull),
		.rxReady(status.rxReady)
	);

	// edge 1: request capture
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			captured.opm <= mmioPkg::idle;
			lastOpm <= mmioPkg::idle;
		end
		else
		begin
			captured.opm <= request.opm;
			lastOpm <= captured.opm;
		end
		captured.addr <= request.addr;
		captured.data <= request.data;
	end

	assign offset = captured.addr[15:0];
	assign blockHit = captured.addr[27:16] == mmioPkg::blockSelect;
	assign isRead = blockHit &&
		(captured.opm == mmioPkg::readWord || captured.opm == mmioPkg::readQuad);
	assign isWrite = blockHit &&
		(captured.opm == mmioPkg::writeWord || captured.opm == mmioPkg::writeQuad);
	assign isQuad = captured.opm == mmioPkg::readQuad;
	assign firstCycle = captured.opm != lastOpm;

	// FIFO side effects once per access
	assign pushValid = isWrite && firstCycle && offset == mmioPkg::regTxData;
	assign popValid = isRead && firstCycle && offset == mmioPkg::regRxData;

	always_ff @(posedge clock)
	begin
		if (popValid)
			heldByte <= headByte;
	end

	always_comb
	begin
		known = 1'b1;
		nextData = 64'd0;
		// later cycles of a data read return the byte held at the first
		rxByte = firstCycle ? headByte : heldByte;
		case (offset)
			mmioPkg::regTimerLow:
				nextData = isQuad ? microseconds : {32'd0, microseconds[31:0]};
			mmioPkg::regTimerHigh:
				nextData = {32'd0, microseconds[63:32]};
			mmioPkg::regCycles:
				nextData = isQuad ? cycles : {32'd0, cycles[31:0]};
			mmioPkg::regRxData:
				nextData = {56'd0, rxByte};
			mmioPkg::regTxData:
				nextData = 64'd0;
			mmioPkg::regStatus:
				nextData = {60'd0, status};
			mmioPkg::regGpioIn:
				nextData = {32'd0, gpioIn};
			mmioPkg::regGpioDir:
				nextData = {32'd0, gpioDir};
			mmioPkg::regGpioOut, mmioPkg::regGpioSet, mmioPkg::regGpioClear:
				nextData = {32'd0, gpioOut};
			default:
				known = 1'b0;
		endcase
		// unknown offsets never answer
		if (known && (isRead || isWrite))
			nextOk = mmioPkg::ok;
		else
			nextOk = mmioPkg::ready;
	end

	// edge 2: writes land
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			gpioOut <= 32'd0;
			gpioDir <= 32'd0;
		end
		else if (isWrite)
		begin
			case (offset)
				mmioPkg::regGpioOut:
					gpioOut <= captured.data[31:0];
				mmioPkg::regGpioDir:
					gpioDir <= captured.data[31:0];
				mmioPkg::regGpioSet:
					gpioOut <= gpioOut | captured.data[31:0];
				mmioPkg::regGpioClear:
					gpioOut <= gpioOut & ~captured.data[31:0];
				default:
					gpioOut <= gpioOut;
			endcase
		end
	end

	// edge 2: registered answer
	always_ff @(posedge clock)
	begin
		if (reset)
			response.ok <= mmioPkg::ready;
		else
			response.ok <= nextOk;
		response.data <= nextData;
	end

endmodule

// ==== verilog/mmioPkg.sv ====
// MMIO bus definitions: operation and status codes, request and response words, register map
package mmioPkg;

	// bit 4 marks a write, bit 3 a read, low bits 2'b11 a quad access
	typedef enum logic [4:0]
	{
		idle      = 5'b00000,
		readWord  = 5'b01010,
		readQuad  = 5'b01011,
		writeWord = 5'b10010,
		writeQuad = 5'b10011
	} mmioOpm;

	// ready means no answer yet
	typedef enum logic [1:0]
	{
		ready = 2'b00,
		ok    = 2'b01
	} mmioOk;

	typedef struct packed
	{
		mmioOpm      opm;
		logic [31:0] addr;
		logic [63:0] data;
	} mmioRequest;

	typedef struct packed
	{
		mmioOk       ok;
		logic [63:0] data;
	} mmioResponse;

	// register offsets within the block
	localparam logic [15:0] regTimerLow  = 16'hE000;
	localparam logic [15:0] regTimerHigh = 16'hE004;
	localparam logic [15:0] regCycles    = 16'hE008;
	localparam logic [15:0] regRxData    = 16'hE010;
	localparam logic [15:0] regTxData    = 16'hE014;
	localparam logic [15:0] regStatus    = 16'hE018;
	localparam logic [15:0] regGpioIn    = 16'hE100;
	localparam logic [15:0] regGpioOut   = 16'hE104;
	localparam logic [15:0] regGpioDir   = 16'hE108;
	localparam logic [15:0] regGpioSet   = 16'hE110;
	localparam logic [15:0] regGpioClear = 16'hE114;

	// address bits 27..16 must match this
	localparam logic [11:0] blockSelect = 12'h000;

endpackage

// ==== verilog/uartPkg.sv ====
// UART and timer constants, FIFO sizing, transmit FSM states and the UART status word
package uartPkg;

	localparam int clockHz = 125_000_000;
	localparam int baudRate = 115200;

	// 16-bit fraction per clock, wraps about once per microsecond
	localparam logic [15:0] tickIncrement =
		16'((64'd65536 * 64'd1_000_000 + clockHz / 2) / clockHz);

	// 16-bit fraction per microsecond, wraps once per bit
	localparam logic [15:0] baudIncrement =
		16'((64'd65536 * baudRate + 64'd500_000) / 64'd1_000_000);

	localparam int fifoDepth = 8;
	localparam int fifoPtrBits = $clog2(fifoDepth);

	typedef enum logic [1:0]
	{
		idle,
		start,
		data,
		stop
	} uartTxState;

	typedef struct packed
	{
		logic txFull;
		logic txEmpty;
		logic rxFull;
		logic rxReady;
	} uartStatus;

endpackage

// ==== verilog/uartReceiver.sv ====
// UART receiver: start-edge detect, mid-bit sampling of 8N1 frames into an eight-entry FIFO
`timescale 1ns/1ps

module uartReceiver
(
	input  logic       clock,
	input  logic       reset,
	input  logic       tick,
	input  logic       popValid,
	input  logic       uartRx,
	output logic [7:0] headByte,
	output logic       rxFull,
	output logic       rxReady
);

	logic [7:0]                      fifo [uartPkg::fifoDepth];
	logic [uartPkg::fifoPtrBits-1:0] writePtr;
	logic [uartPkg::fifoPtrBits-1:0] readPtr;
	logic [uartPkg::fifoPtrBits:0]   count;
	logic [2:0]                      rxPipe;
	logic                            sample;
	logic                            startEdge;
	logic [15:0]                     phase;
	logic [15:0]                     nextPhase;
	logic                            strobe;
	logic                            busy;
	logic [3:0]                      bitIndex;
	logic [7:0]                      shifter;
	logic                            push;
	logic                            pop;

	// two sync stages, third stage only for edge detect
	assign sample = rxPipe[1];
	assign startEdge = rxPipe[2] && !rxPipe[1] && !busy;

	// phase restarts at the edge, so bit 15 rising marks mid-bit
	assign nextPhase = phase + uartPkg::baudIncrement;
	assign strobe = tick && nextPhase[15] && !phase[15];

	// only frames with a high stop bit are kept
	assign push = strobe && busy && bitIndex == 4'd9 && sample && !rxFull;
	assign pop = popValid && rxReady;

	assign rxReady = count != '0;
	assign rxFull = count == (uartPkg::fifoPtrBits + 1)'(uartPkg::fifoDepth);
	assign headByte = fifo[readPtr];

	always_ff @(posedge clock)
	begin
		if (reset)
			rxPipe <= 3'b111;
		else
			rxPipe <= {rxPipe[1:0], uartRx};
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			phase <= 16'd0;
			bitIndex <= 4'd0;
		end
		else if (startEdge)
		begin
			busy <= 1'b1;
			phase <= 16'd0;
			bitIndex <= 4'd0;
		end
		else
		begin
			if (tick)
				phase <= nextPhase;
			if (strobe && busy)
			begin
				// glitch instead of a start bit, or stop bit taken
				if ((bitIndex == 4'd0 && sample) || bitIndex == 4'd9)
					busy <= 1'b0;
				bitIndex <= bitIndex + 4'd1;
			end
		end
	end

	// data bits arrive LSB first
	always_ff @(posedge clock)
	begin
		if (strobe && busy && bitIndex != 4'd0 && bitIndex != 4'd9)
			shifter <= {sample, shifter[7:1]};
	end

	always_ff @(posedge clock)
	begin
		if (push)
			fifo[writePtr] <= shifter;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			writePtr <= '0;
			readPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				writePtr <= writePtr + 1'b1;
			if (pop)
				readPtr <= readPtr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

endmodule

// ==== verilog/uartTransmitter.sv ====
// UART transmitter: eight-entry byte FIFO feeding an 8N1 shifter on the TX line
`timescale 1ns/1ps

module uartTransmitter
(
	input  logic       clock,
	input  logic       reset,
	input  logic       tick,
	input  logic       pushValid,
	input  logic [7:0] pushByte,
	output logic       uartTx,
	output logic       txFull,
	output logic       txEmpty
);

	logic [7:0]                      fifo [uartPkg::fifoDepth];
	logic [uartPkg::fifoPtrBits-1:0] writePtr;
	logic [uartPkg::fifoPtrBits-1:0] readPtr;
	logic [uartPkg::fifoPtrBits:0]   count;
	logic [15:0]                     phase;
	logic [15:0]                     nextPhase;
	logic                            baudCarry;
	logic                            baudStep;
	logic                            push;
	logic                            pop;
	logic                            moreQueued;
	logic [7:0]                      shifter;
	logic [2:0]                      bitIndex;
	uartPkg::uartTxState             state;

	assign txFull = count == (uartPkg::fifoPtrBits + 1)'(uartPkg::fifoDepth);
	assign txEmpty = count == '0;
	assign moreQueued = count > (uartPkg::fifoPtrBits + 1)'(1);

	// baud phase advances once per microsecond
	assign {baudCarry, nextPhase} = {1'b0, phase} + {1'b0, uartPkg::baudIncrement};
	assign baudStep = tick && baudCarry;

	// full FIFO drops the byte
	assign push = pushValid && !txFull;
	assign pop = baudStep && state == uartPkg::stop;

	always_ff @(posedge clock)
	begin
		if (push)
			fifo[writePtr] <= pushByte;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			writePtr <= '0;
			readPtr <= '0;
			count <= '0;
			phase <= 16'd0;
		end
		else
		begin
			if (tick)
				phase <= nextPhase;
			if (push)
				writePtr <= writePtr + 1'b1;
			if (pop)
				readPtr <= readPtr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	// head byte loads on frame start, then shifts out LSB first
	always_ff @(posedge clock)
	begin
		if (baudStep)
		begin
			if (state == uartPkg::idle)
				shifter <= fifo[readPtr];
			else if (state == uartPkg::stop)
				shifter <= fifo[readPtr + 1'b1];
			else if (state == uartPkg::data)
				shifter <= shifter >> 1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= uartPkg::idle;
			uartTx <= 1'b1;
			bitIndex <= 3'd0;
		end
		else if (baudStep)
		begin
			case (state)
				uartPkg::idle:
				begin
					if (!txEmpty)
					begin
						state <= uartPkg::start;
						uartTx <= 1'b0;
					end
				end
				uartPkg::start:
				begin
					state <= uartPkg::data;
					uartTx <= shifter[0];
					bitIndex <= 3'd0;
				end
				uartPkg::data:
				begin
					if (bitIndex == 3'd7)
					begin
						state <= uartPkg::stop;
						uartTx <= 1'b1;
					end
					else
					begin
						uartTx <= shifter[1];
						bitIndex <= bitIndex + 3'd1;
					end
				end
				uartPkg::stop:
				begin
					// back-to-back frames skip idle
					if (moreQueued)
					begin
						state <= uartPkg::start;
						uartTx <= 1'b0;
					end
					else
						state <= uartPkg::idle;
				end
				default:
					state <= uartPkg::idle;
			endcase
		end
	end

endmodule
